/* design/wbc_pkg.sv */
package wbc_pkg;

  // ----------------------------------------------------------
  // Bus and queue sizes
  // ----------------------------------------------------------
  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 32;
  localparam int SEL_W        = DATA_W / 8;
  localparam int FIFO_ASIZE   = 2;
  localparam int TAG_W        = FIFO_ASIZE + 2;
  localparam int INFLIGHT_MAX = 8;
  localparam int MEM_WORDS    = 16;

  // Request queue, 4 deep
  localparam int REQ_DEPTH    = 1 << FIFO_ASIZE;
  localparam int REQ_CNT_W    = FIFO_ASIZE + 1;

  // Response buffer, 8 deep
  localparam int RSP_AW       = FIFO_ASIZE + 1;
  localparam int RSP_DEPTH    = 1 << RSP_AW;
  localparam int RSP_CNT_W    = RSP_AW + 1;

  // In-flight direction record
  localparam int INF_IDX_W    = $clog2(INFLIGHT_MAX);
  localparam int INF_CNT_W    = INF_IDX_W + 1;

  // Memory slave word index
  localparam int MEM_AW       = $clog2(MEM_WORDS);

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } wb_op_e;

  typedef struct packed {
    wb_op_e              op;
    logic [ADDR_W-1:0]   addr;
    logic [SEL_W-1:0]    sel;
    logic [DATA_W-1:0]   data;
  } wbc_req_t;

  // Queued request with its age stamp
  typedef struct packed {
    wbc_req_t            req;
    logic [TAG_W-1:0]    tag;
  } wbc_hdr_t;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DRAIN
  } arb_state_e;

endpackage

/* design/wbc_fifo.sv */
`timescale 1ns/100ps

module wbc_fifo (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wr_en_i,
  input  logic [wbc_pkg::DATA_W-1:0]    wr_data_i,
  input  logic                          rd_en_i,
  output logic [wbc_pkg::DATA_W-1:0]    rd_data_o,
  output logic [wbc_pkg::RSP_CNT_W-1:0] count_o,
  output logic                          empty_o,
  output logic                          full_o
);
  import wbc_pkg::*;

  logic [DATA_W-1:0]    mem [RSP_DEPTH];
  logic [RSP_AW-1:0]    wr_ptr;
  logic [RSP_AW-1:0]    rd_ptr;
  logic                 do_wr;
  logic                 do_rd;

  // Writes into a full buffer and reads from an empty one are dropped
  assign do_wr = wr_en_i & !full_o;
  assign do_rd = rd_en_i & !empty_o;

  assign empty_o   = (count_o == '0);
  assign full_o    = (count_o == RSP_CNT_W'(RSP_DEPTH));
  assign rd_data_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

endmodule

/* design/wbc_master_port.sv */
`timescale 1ns/100ps

module wbc_master_port (
  input  logic                          clk,
  input  logic                          rst,
  // Request from the master
  input  logic                          req_valid_i,
  input  wbc_pkg::wbc_req_t             req_i,
  output logic                          req_ready_o,
  // Age stamp and enqueue report
  input  logic [wbc_pkg::TAG_W-1:0]     tag_i,
  output logic                          enq_o,
  // Head of the request queue
  output wbc_pkg::wbc_hdr_t             hdr_o,
  output logic                          hdr_empty_o,
  input  logic                          hdr_rden_i,
  // Response buffer write side
  input  logic                          rsp_wren_i,
  input  logic [wbc_pkg::DATA_W-1:0]    rsp_wdata_i,
  output logic [wbc_pkg::RSP_CNT_W-1:0] rsp_space_o,
  // Response to the master
  output logic                          rsp_valid_o,
  output logic [wbc_pkg::DATA_W-1:0]    rsp_data_o,
  input  logic                          rsp_ready_i
);
  import wbc_pkg::*;

  wbc_hdr_t              req_q [REQ_DEPTH];
  logic [FIFO_ASIZE-1:0] wr_ptr;
  logic [FIFO_ASIZE-1:0] rd_ptr;
  logic [REQ_CNT_W-1:0]  req_cnt;
  logic [RSP_CNT_W-1:0]  rsp_count;
  logic [RSP_CNT_W-1:0]  owed_q;
  logic                  rsp_empty;

  // ----------------------------------------------------------
  // Request queue
  // ----------------------------------------------------------
  assign req_ready_o = (req_cnt != REQ_CNT_W'(REQ_DEPTH));
  assign enq_o       = req_valid_i & req_ready_o;
  assign hdr_empty_o = (req_cnt == '0);
  assign hdr_o       = req_q[rd_ptr];

  // Stamp each request with the current tag as it enters
  always_ff @(posedge clk) begin
    if (enq_o) req_q[wr_ptr] <= '{req: req_i, tag: tag_i};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      req_cnt <= '0;
    end else begin
      if (enq_o)      wr_ptr <= wr_ptr + 1'b1;
      if (hdr_rden_i) rd_ptr <= rd_ptr + 1'b1;
      req_cnt <= req_cnt + REQ_CNT_W'(enq_o) - REQ_CNT_W'(hdr_rden_i);
    end
  end

  // ----------------------------------------------------------
  // Response side
  // ----------------------------------------------------------
  // Responses owed: issued on the bus but not yet acked
  always_ff @(posedge clk) begin
    if (rst) owed_q <= '0;
    else     owed_q <= owed_q + RSP_CNT_W'(hdr_rden_i) - RSP_CNT_W'(rsp_wren_i);
  end

  // Free slots not already promised to a request in flight
  assign rsp_space_o = RSP_CNT_W'(RSP_DEPTH) - rsp_count - owed_q;
  assign rsp_valid_o = !rsp_empty;

  wbc_fifo u_rsp_fifo (
    .clk       (clk),
    .rst       (rst),
    .wr_en_i   (rsp_wren_i),
    .wr_data_i (rsp_wdata_i),
    .rd_en_i   (rsp_valid_o & rsp_ready_i),
    .rd_data_o (rsp_data_o),
    .count_o   (rsp_count),
    .empty_o   (rsp_empty),
    .full_o    ()
  );

endmodule

/* design/wbc_slave_port.sv */
`timescale 1ns/100ps

module wbc_slave_port (
  input  logic                          clk,
  input  logic                          rst,
  // Master 0 port
  input  wbc_pkg::wbc_hdr_t             m0_hdr_i,
  input  logic                          m0_hdr_empty_i,
  output logic                          m0_hdr_rden_o,
  input  logic [wbc_pkg::RSP_CNT_W-1:0] m0_rsp_space_i,
  output logic                          m0_rsp_wren_o,
  output logic [wbc_pkg::DATA_W-1:0]    m0_rsp_wdata_o,
  // Master 1 port
  input  wbc_pkg::wbc_hdr_t             m1_hdr_i,
  input  logic                          m1_hdr_empty_i,
  output logic                          m1_hdr_rden_o,
  input  logic [wbc_pkg::RSP_CNT_W-1:0] m1_rsp_space_i,
  output logic                          m1_rsp_wren_o,
  output logic [wbc_pkg::DATA_W-1:0]    m1_rsp_wdata_o,
  // Sequence tag
  input  logic                          enq0_i,
  input  logic                          enq1_i,
  output logic [wbc_pkg::TAG_W-1:0]     tag_o,
  // Wishbone master side
  output logic                          cyc_o,
  output logic                          stb_o,
  output logic                          we_o,
  output logic [wbc_pkg::ADDR_W-1:0]    addr_o,
  output logic [wbc_pkg::SEL_W-1:0]     sel_o,
  output logic [wbc_pkg::DATA_W-1:0]    dat_o,
  input  logic [wbc_pkg::DATA_W-1:0]    dat_i,
  input  logic                          stall_i,
  input  logic                          ack_i
);
  import wbc_pkg::*;

  logic                    m0_ok;
  logic                    m1_ok;
  logic                    m1_dir;
  logic                    accept;
  logic                    rec_full;
  wbc_hdr_t                hdr_sel;
  logic [INFLIGHT_MAX-1:0] dir_rec;
  logic [INFLIGHT_MAX-1:0] rec_next;
  logic [INF_CNT_W-1:0]    inflight_cnt;
  logic [INF_CNT_W-1:0]    inflight_next;
  logic [INF_CNT_W-1:0]    wr_pos;
  arb_state_e              state;
  arb_state_e              state_next;

  // True when tag a is older than tag b; top bit flip means wrap
  function automatic logic tag_older(input logic [TAG_W-1:0] a, input logic [TAG_W-1:0] b);
    logic wrap;
    wrap = a[TAG_W-1] ^ b[TAG_W-1];
    return wrap ? (a[TAG_W-2:0] > b[TAG_W-2:0]) : (a[TAG_W-2:0] < b[TAG_W-2:0]);
  endfunction

  // ----------------------------------------------------------
  // Age arbitration and request issue
  // ----------------------------------------------------------
  // A head only competes when its response buffer has room
  assign m0_ok  = !m0_hdr_empty_i & (m0_rsp_space_i != '0);
  assign m1_ok  = !m1_hdr_empty_i & (m1_rsp_space_i != '0);
  assign m1_dir = !m0_ok | (m1_ok & tag_older(m1_hdr_i.tag, m0_hdr_i.tag));

  assign rec_full = (inflight_cnt == INF_CNT_W'(INFLIGHT_MAX));
  assign hdr_sel  = m1_dir ? m1_hdr_i : m0_hdr_i;

  assign cyc_o  = !m0_hdr_empty_i | !m1_hdr_empty_i | (state != IDLE);
  assign stb_o  = (m0_ok | m1_ok) & !rec_full;
  assign we_o   = (hdr_sel.req.op == OP_WRITE);
  assign addr_o = hdr_sel.req.addr;
  assign sel_o  = hdr_sel.req.sel;
  assign dat_o  = hdr_sel.req.data;
  assign accept = stb_o & !stall_i;

  assign m0_hdr_rden_o = accept & !m1_dir;
  assign m1_hdr_rden_o = accept & m1_dir;

  // ----------------------------------------------------------
  // In-flight record, oldest entry at bit 0
  // ----------------------------------------------------------
  always_comb begin
    rec_next = ack_i ? (dir_rec >> 1) : dir_rec;
    wr_pos   = ack_i ? (inflight_cnt - 1'b1) : inflight_cnt;
    if (accept) rec_next[wr_pos[INF_IDX_W-1:0]] = m1_dir;
    inflight_next = wr_pos + INF_CNT_W'(accept);
  end

  // Ack data goes where the oldest request came from
  assign m0_rsp_wren_o  = ack_i & !dir_rec[0];
  assign m1_rsp_wren_o  = ack_i & dir_rec[0];
  assign m0_rsp_wdata_o = dat_i;
  assign m1_rsp_wdata_o = dat_i;

  always_comb begin
    if (inflight_next == '0) state_next = IDLE;
    else if (accept)         state_next = BUSY;
    else                     state_next = DRAIN;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dir_rec      <= '0;
      inflight_cnt <= '0;
      state        <= IDLE;
      tag_o        <= '0;
    end else begin
      dir_rec      <= rec_next;
      inflight_cnt <= inflight_next;
      state        <= state_next;
      // Same-cycle enqueues on both ports share one tag
      if (enq0_i | enq1_i) tag_o <= tag_o + 1'b1;
    end
  end

endmodule

/* design/wbc_mem_slave.sv */
`timescale 1ns/100ps

module wbc_mem_slave (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [wbc_pkg::ADDR_W-1:0]  addr_i,
  input  logic [wbc_pkg::SEL_W-1:0]   sel_i,
  input  logic [wbc_pkg::DATA_W-1:0]  dat_i,
  output logic [wbc_pkg::DATA_W-1:0]  dat_o,
  output logic                        stall_o,
  output logic                        ack_o
);
  import wbc_pkg::*;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [1:0]        stall_cnt;
  logic [MEM_AW-1:0] word_idx;
  logic [DATA_W-1:0] merged;
  logic              accept;

  assign word_idx = addr_i[MEM_AW+1:2];
  assign stall_o  = (stall_cnt == 2'd3);
  assign accept   = cyc_i & stb_i & !stall_o;

  // Byte lane merge of write data into the stored word
  always_comb begin
    for (int i = 0; i < SEL_W; i++) begin
      merged[8*i +: 8] = sel_i[i] ? dat_i[8*i +: 8] : mem[word_idx][8*i +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      if (we_i) mem[word_idx] <= merged;
      dat_o <= we_i ? merged : mem[word_idx];
    end
  end

  // Free-running stall pattern, one cycle in four
  always_ff @(posedge clk) begin
    if (rst) begin
      stall_cnt <= '0;
      ack_o     <= 1'b0;
    end else begin
      stall_cnt <= stall_cnt + 1'b1;
      ack_o     <= accept;
    end
  end

endmodule

/* design/wbc_top.sv */
`timescale 1ns/100ps

module wbc_top (
  input  logic                       clk,
  input  logic                       rst,
  // Master 0
  input  logic                       m0_req_valid_i,
  input  wbc_pkg::wbc_req_t          m0_req_i,
  output logic                       m0_req_ready_o,
  output logic                       m0_rsp_valid_o,
  output logic [wbc_pkg::DATA_W-1:0] m0_rsp_data_o,
  input  logic                       m0_rsp_ready_i,
  // Master 1
  input  logic                       m1_req_valid_i,
  input  wbc_pkg::wbc_req_t          m1_req_i,
  output logic                       m1_req_ready_o,
  output logic                       m1_rsp_valid_o,
  output logic [wbc_pkg::DATA_W-1:0] m1_rsp_data_o,
  input  logic                       m1_rsp_ready_i
);
  import wbc_pkg::*;

  wbc_hdr_t             m0_hdr;
  wbc_hdr_t             m1_hdr;
  logic                 m0_hdr_empty;
  logic                 m1_hdr_empty;
  logic                 m0_hdr_rden;
  logic                 m1_hdr_rden;
  logic [RSP_CNT_W-1:0] m0_rsp_space;
  logic [RSP_CNT_W-1:0] m1_rsp_space;
  logic                 m0_rsp_wren;
  logic                 m1_rsp_wren;
  logic [DATA_W-1:0]    m0_rsp_wdata;
  logic [DATA_W-1:0]    m1_rsp_wdata;
  logic                 m0_enq;
  logic                 m1_enq;
  logic [TAG_W-1:0]     tag;

  // Wishbone bus between the arbiter and the memory
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [ADDR_W-1:0]    wb_addr;
  logic [SEL_W-1:0]     wb_sel;
  logic [DATA_W-1:0]    wb_dat_w;
  logic [DATA_W-1:0]    wb_dat_r;
  logic                 wb_stall;
  logic                 wb_ack;

  wbc_master_port u_m0_port (
    .clk         (clk),             .rst         (rst),
    .req_valid_i (m0_req_valid_i),  .req_i       (m0_req_i),
    .req_ready_o (m0_req_ready_o),  .tag_i       (tag),
    .enq_o       (m0_enq),          .hdr_o       (m0_hdr),
    .hdr_empty_o (m0_hdr_empty),    .hdr_rden_i  (m0_hdr_rden),
    .rsp_wren_i  (m0_rsp_wren),     .rsp_wdata_i (m0_rsp_wdata),
    .rsp_space_o (m0_rsp_space),    .rsp_valid_o (m0_rsp_valid_o),
    .rsp_data_o  (m0_rsp_data_o),   .rsp_ready_i (m0_rsp_ready_i)
  );

  wbc_master_port u_m1_port (
    .clk         (clk),             .rst         (rst),
    .req_valid_i (m1_req_valid_i),  .req_i       (m1_req_i),
    .req_ready_o (m1_req_ready_o),  .tag_i       (tag),
    .enq_o       (m1_enq),          .hdr_o       (m1_hdr),
    .hdr_empty_o (m1_hdr_empty),    .hdr_rden_i  (m1_hdr_rden),
    .rsp_wren_i  (m1_rsp_wren),     .rsp_wdata_i (m1_rsp_wdata),
    .rsp_space_o (m1_rsp_space),    .rsp_valid_o (m1_rsp_valid_o),
    .rsp_data_o  (m1_rsp_data_o),   .rsp_ready_i (m1_rsp_ready_i)
  );

  wbc_slave_port u_slave_port (
    .clk            (clk),           .rst            (rst),
    .m0_hdr_i       (m0_hdr),        .m0_hdr_empty_i (m0_hdr_empty),
    .m0_hdr_rden_o  (m0_hdr_rden),   .m0_rsp_space_i (m0_rsp_space),
    .m0_rsp_wren_o  (m0_rsp_wren),   .m0_rsp_wdata_o (m0_rsp_wdata),
    .m1_hdr_i       (m1_hdr),        .m1_hdr_empty_i (m1_hdr_empty),
    .m1_hdr_rden_o  (m1_hdr_rden),   .m1_rsp_space_i (m1_rsp_space),
    .m1_rsp_wren_o  (m1_rsp_wren),   .m1_rsp_wdata_o (m1_rsp_wdata),
    .enq0_i         (m0_enq),        .enq1_i         (m1_enq),
    .tag_o          (tag),
    .cyc_o          (wb_cyc),        .stb_o          (wb_stb),
    .we_o           (wb_we),         .addr_o         (wb_addr),
    .sel_o          (wb_sel),        .dat_o          (wb_dat_w),
    .dat_i          (wb_dat_r),      .stall_i        (wb_stall),
    .ack_i          (wb_ack)
  );

  wbc_mem_slave u_mem (
    .clk     (clk),      .rst     (rst),
    .cyc_i   (wb_cyc),   .stb_i   (wb_stb),
    .we_i    (wb_we),    .addr_i  (wb_addr),
    .sel_i   (wb_sel),   .dat_i   (wb_dat_w),
    .dat_o   (wb_dat_r), .stall_o (wb_stall),
    .ack_o   (wb_ack)
  );

endmodule

/* tests/wbc_properties.sv */
`timescale 1ns/100ps

module wbc_properties (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cyc_o,
  input  logic                          stb_o,
  input  logic                          ack_i,
  input  logic [wbc_pkg::INF_CNT_W-1:0] inflight_cnt
);
  import wbc_pkg::*;

  // Strobe only inside a bus cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb_o |-> cyc_o)
    else $error("stb_o high while cyc_o is low");

  // In-flight record never holds more than its depth
  a_rec_limit: assert property (@(posedge clk) disable iff (rst)
    inflight_cnt <= INF_CNT_W'(INFLIGHT_MAX))
    else $error("in-flight record holds %0d entries", inflight_cnt);

  // Every ack belongs to a recorded request
  a_ack_owned: assert property (@(posedge clk) disable iff (rst) ack_i |-> (inflight_cnt != '0))
    else $error("ack_i arrived with an empty in-flight record");

endmodule

bind wbc_slave_port wbc_properties u_props (
  .clk          (clk),
  .rst          (rst),
  .cyc_o        (cyc_o),
  .stb_o        (stb_o),
  .ack_i        (ack_i),
  .inflight_cnt (inflight_cnt)
);

/* tests/wbc_tb.sv */
`timescale 1ns/100ps

module wbc_tb;
  import wbc_pkg::*;

  localparam int MAX_VEC = 32;
  localparam int COLS    = 7;

  logic                   clk;
  logic                   rst;
  logic [1:0]             req_valid;
  wbc_req_t [1:0]         req_in;
  logic [1:0]             req_ready;
  logic [1:0]             rsp_valid;
  logic [1:0][DATA_W-1:0] rsp_data;
  logic [1:0]             rsp_ready;

  logic [31:0] vec_words [COLS*MAX_VEC];
  int          n_vec;
  int          list_idx [2][MAX_VEC];
  int          list_len [2];
  time         last_rsp [2];
  int          err_cnt;
  int          tests_run;
  int          tests_failed;
  bit          m1_sent;
  bit          hold_ready;
  logic [15:0] lfsr = 16'd4;

  wbc_top uut (
    .clk            (clk),            .rst            (rst),
    .m0_req_valid_i (req_valid[0]),   .m0_req_i       (req_in[0]),
    .m0_req_ready_o (req_ready[0]),   .m0_rsp_valid_o (rsp_valid[0]),
    .m0_rsp_data_o  (rsp_data[0]),    .m0_rsp_ready_i (rsp_ready[0]),
    .m1_req_valid_i (req_valid[1]),   .m1_req_i       (req_in[1]),
    .m1_req_ready_o (req_ready[1]),   .m1_rsp_valid_o (rsp_valid[1]),
    .m1_rsp_data_o  (rsp_data[1]),    .m1_rsp_ready_i (rsp_ready[1])
  );

  always #10 clk = ~clk;

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // Random response back-pressure, one LFSR bit per master per cycle
  always @(posedge clk) begin
    if (hold_ready) begin
      rsp_ready <= 2'b11;
    end else begin
      lfsr = lfsr_step(lfsr);
      rsp_ready[0] <= lfsr[0];
      lfsr = lfsr_step(lfsr);
      rsp_ready[1] <= lfsr[0];
    end
  end

  // ----------------------------------------------------------
  // Vector loading and expected-value model
  // ----------------------------------------------------------
  task automatic load_vectors();
    logic [31:0] model [MEM_WORDS];
    logic [31:0] want;
    logic [3:0]  sel;
    int          a;
    for (int i = 0; i < COLS*MAX_VEC; i++) vec_words[i] = '0;
    $readmemh("tests/wbc_testdata.txt", vec_words);
    n_vec = 0;
    while (n_vec < MAX_VEC && vec_words[COLS*n_vec] != 0) n_vec++;
    for (int v = 0; v < n_vec; v++) begin
      a   = int'(vec_words[COLS*v+3][5:2]);
      sel = vec_words[COLS*v+4][3:0];
      if (vec_words[COLS*v+2][0]) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (sel[b]) model[a][8*b +: 8] = vec_words[COLS*v+5][8*b +: 8];
        end
      end
      want = model[a];
      if (want !== vec_words[COLS*v+6]) begin
        $display("Data file vector %0d expects %08h but the write history gives %08h",
                 v, vec_words[COLS*v+6], want);
        err_cnt++;
      end
    end
  endtask

  // ----------------------------------------------------------
  // Master drivers and response collectors
  // ----------------------------------------------------------
  task automatic drive_master(input int m, input bit after_m1);
    int v;
    if (after_m1) wait (m1_sent);
    @(posedge clk);
    for (int k = 0; k < list_len[m]; k++) begin
      v = list_idx[m][k];
      req_valid[m] <= 1'b1;
      req_in[m]    <= '{op:   wb_op_e'(vec_words[COLS*v+2][0]),
                        addr: vec_words[COLS*v+3],
                        sel:  vec_words[COLS*v+4][SEL_W-1:0],
                        data: vec_words[COLS*v+5]};
      @(negedge clk);
      while (!req_ready[m]) @(negedge clk);
      @(posedge clk);
      // Master 0 joins once master 1 holds the oldest tag
      if (m == 1) m1_sent = 1'b1;
    end
    req_valid[m] <= 1'b0;
  endtask

  task automatic collect_master(input int m);
    int          v;
    logic [31:0] expv;
    for (int k = 0; k < list_len[m]; k++) begin
      v    = list_idx[m][k];
      expv = vec_words[COLS*v+6];
      @(negedge clk);
      while (!(rsp_valid[m] && rsp_ready[m])) @(negedge clk);
      if (rsp_data[m] !== expv) begin
        $display("ERR t=%0t m%0d_rsp_data_o expected %08h actual %08h",
                 $time, m, expv, rsp_data[m]);
        err_cnt++;
      end
      last_rsp[m] = $time;
    end
  endtask

  task automatic run_group(input int g);
    int m;
    int errs_at_start;
    bit m1_first;
    bit extra;
    errs_at_start = err_cnt;
    list_len[0]   = 0;
    list_len[1]   = 0;
    m1_first      = 1'b0;
    extra         = 1'b0;
    for (int v = 0; v < n_vec; v++) begin
      if (vec_words[COLS*v] == g) begin
        m = int'(vec_words[COLS*v+1][0]);
        if (list_len[0] + list_len[1] == 0) m1_first = (m == 1);
        list_idx[m][list_len[m]] = v;
        list_len[m]++;
      end
    end
    if (list_len[0] + list_len[1] == 0) return;
    // Age group keeps both response ports open so ack order shows directly
    hold_ready = m1_first;
    m1_sent    = 1'b0;
    fork
      drive_master(0, m1_first);
      drive_master(1, 1'b0);
      collect_master(0);
      collect_master(1);
    join
    if (m1_first && list_len[0] > 0 && list_len[1] > 0 && !(last_rsp[1] < last_rsp[0])) begin
      $display("Group %0d: master 1 responses not complete before master 0 finished", g);
      err_cnt++;
    end
    // Any word left in a response buffer is a duplicate
    repeat (4) begin
      @(negedge clk);
      if (rsp_valid != 2'b00) extra = 1'b1;
    end
    if (extra) begin
      $display("Group %0d: extra response word after all expected responses", g);
      err_cnt++;
    end
    hold_ready = 1'b0;
    tests_run++;
    if (err_cnt != errs_at_start) tests_failed++;
    $display("group %0d: %0d requests on m0, %0d on m1, %s", g, list_len[0], list_len[1],
             (err_cnt == errs_at_start) ? "ok" : "FAILED");
  endtask

  // ----------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------
  initial begin
    wait (n_vec > 0);
    repeat (200 * n_vec + 100) @(posedge clk);
    $display("Timeout: responses still missing after %0d cycles", 200 * n_vec + 100);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int last_group;
    int errs_at_start;
    clk        = 1'b0;
    rst        = 1'b1;
    req_valid  = '0;
    req_in     = '0;
    rsp_ready  = '0;
    hold_ready = 1'b0;
    m1_sent    = 1'b0;
    load_vectors();
    if (n_vec == 0) begin
      $display("No vectors found in tests/wbc_testdata.txt");
      err_cnt++;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Reset state of the master ports
    @(negedge clk);
    errs_at_start = err_cnt;
    for (int m = 0; m < 2; m++) begin
      if (req_ready[m] !== 1'b1) begin
        $display("ERR t=%0t m%0d_req_ready_o expected 1 actual %b", $time, m, req_ready[m]);
        err_cnt++;
      end
      if (rsp_valid[m] !== 1'b0) begin
        $display("ERR t=%0t m%0d_rsp_valid_o expected 0 actual %b", $time, m, rsp_valid[m]);
        err_cnt++;
      end
    end
    tests_run++;
    if (err_cnt != errs_at_start) tests_failed++;
    $display("reset state: %s", (err_cnt == errs_at_start) ? "ok" : "FAILED");

    last_group = (n_vec > 0) ? int'(vec_words[COLS*(n_vec-1)]) : 0;
    for (int g = 1; g <= last_group; g++) run_group(g);

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tests/wbc_testdata.txt */
// group master op(0 read, 1 write) addr sel data expected_response, all hex
// a group whose first line is on master 1 issues master 1 first
1 0 1 00000000 f 11111111 11111111
1 1 1 00000020 f aaaaaaaa aaaaaaaa
1 0 1 00000004 f 22222222 22222222
1 1 1 00000024 f bbbbbbbb bbbbbbbb
1 0 1 00000008 f 33333333 33333333
1 1 1 00000028 f cccccccc cccccccc
2 0 1 00000000 1 000000ee 111111ee
2 0 1 00000004 6 00ddcc00 22ddcc22
2 1 1 00000020 8 55000000 55aaaaaa
2 1 1 00000024 3 00009999 bbbb9999
3 0 0 00000000 0 00000000 111111ee
3 1 0 00000020 0 00000000 55aaaaaa
3 0 0 00000004 0 00000000 22ddcc22
3 1 0 00000024 0 00000000 bbbb9999
3 0 1 00000008 c 77660000 77663333
3 1 1 00000028 1 00000042 cccccc42
3 0 0 00000008 0 00000000 77663333
3 1 0 00000028 0 00000000 cccccc42
4 1 0 00000000 0 00000000 111111ee
4 1 1 0000000c f 0f0f0f0f 0f0f0f0f
4 1 0 0000000c 0 00000000 0f0f0f0f
4 0 0 00000020 0 00000000 55aaaaaa
4 0 1 0000002c f f0f0f0f0 f0f0f0f0
4 0 0 0000002c 0 00000000 f0f0f0f0
5 0 0 00000008 0 00000000 77663333
5 0 0 0000000c 0 00000000 0f0f0f0f
5 0 0 00000004 0 00000000 22ddcc22
5 1 0 00000028 0 00000000 cccccc42
5 1 0 0000002c 0 00000000 f0f0f0f0
5 1 0 00000024 0 00000000 bbbb9999

/* wbc_top.f */
design/wbc_pkg.sv
design/wbc_fifo.sv
design/wbc_master_port.sv
design/wbc_slave_port.sv
design/wbc_mem_slave.sv
design/wbc_top.sv
tests/wbc_properties.sv
tests/wbc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the wbc testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f wbc_top.f \
  --top-module wbc_tb --Mdir obj_dir -o wbc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/wbc_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
